//--- src/id_pkg.sv
`default_nettype none

package id_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // bit positions inside alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_kind_t;

    // inst[31:15], three-register and shift-immediate forms
    localparam logic [16:0] OP17_ADD_W  = 17'h00020;
    localparam logic [16:0] OP17_SUB_W  = 17'h00022;
    localparam logic [16:0] OP17_SLT    = 17'h00024;
    localparam logic [16:0] OP17_SLTU   = 17'h00025;
    localparam logic [16:0] OP17_NOR    = 17'h00028;
    localparam logic [16:0] OP17_AND    = 17'h00029;
    localparam logic [16:0] OP17_OR     = 17'h0002a;
    localparam logic [16:0] OP17_XOR    = 17'h0002b;
    localparam logic [16:0] OP17_SLL_W  = 17'h0002e;
    localparam logic [16:0] OP17_SRL_W  = 17'h0002f;
    localparam logic [16:0] OP17_SRA_W  = 17'h00030;
    localparam logic [16:0] OP17_SLLI_W = 17'h00081;
    localparam logic [16:0] OP17_SRLI_W = 17'h00089;
    localparam logic [16:0] OP17_SRAI_W = 17'h00091;

    // inst[31:22], 12-bit immediate forms and memory
    localparam logic [9:0] OP10_SLTI   = 10'h008;
    localparam logic [9:0] OP10_SLTUI  = 10'h009;
    localparam logic [9:0] OP10_ADDI_W = 10'h00a;
    localparam logic [9:0] OP10_ANDI   = 10'h00d;
    localparam logic [9:0] OP10_ORI    = 10'h00e;
    localparam logic [9:0] OP10_XORI   = 10'h00f;
    localparam logic [9:0] OP10_LD_W   = 10'h0a2;
    localparam logic [9:0] OP10_ST_W   = 10'h0a6;

    localparam logic [6:0] OP7_LU12I_W = 7'h0a; // inst[31:25]

    // inst[31:26], branches
    localparam logic [5:0] OP6_JIRL = 6'h13;
    localparam logic [5:0] OP6_B    = 6'h14;
    localparam logic [5:0] OP6_BL   = 6'h15;
    localparam logic [5:0] OP6_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BNE  = 6'h17;
    localparam logic [5:0] OP6_BLT  = 6'h18;
    localparam logic [5:0] OP6_BGE  = 6'h19;
    localparam logic [5:0] OP6_BLTU = 6'h1a;
    localparam logic [5:0] OP6_BGEU = 6'h1b;

    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_t   alu_op;
        br_kind_t  br_kind;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      gr_we;
        logic      mem_we;
        logic      load;
        reg_addr_t dest;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        xlen_t     imm;
        xlen_t     br_offs;
    } ctrl_t;

    typedef struct packed {
        logic      we;
        logic      load;
        reg_addr_t dest;
        xlen_t     result;
    } fwd_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      load;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        xlen_t     imm;
        xlen_t     rj_value;
        xlen_t     rkd_value;
        xlen_t     pc;
    } issue_pkt_t;

    typedef struct packed {
        logic  stall;
        logic  taken;
        xlen_t target;
    } branch_t;

endpackage

`default_nettype wire

//--- src/inst_decoder.sv
`default_nettype none

module inst_decoder (
    input  id_pkg::xlen_t inst,
    output id_pkg::ctrl_t ctrl
);
    import id_pkg::*;

    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic inst_and, inst_nor, inst_or, inst_xor;
    logic inst_sll_w, inst_srl_w, inst_sra_w;
    logic inst_slli_w, inst_srli_w, inst_srai_w;
    logic inst_addi_w, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
    logic inst_lu12i_w, inst_ld_w, inst_st_w;
    logic inst_jirl, inst_b, inst_bl;
    logic is_cond_br;
    logic need_ui12;
    logic src2_is_4;

    alu_op_t  alu_op;
    br_kind_t br_kind;
    xlen_t    imm;
    xlen_t    br_offs;

    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]}; // offs[25:16] sits in the rd/rj slots

    assign inst_add_w   = (op17 == OP17_ADD_W);
    assign inst_sub_w   = (op17 == OP17_SUB_W);
    assign inst_slt     = (op17 == OP17_SLT);
    assign inst_sltu    = (op17 == OP17_SLTU);
    assign inst_nor     = (op17 == OP17_NOR);
    assign inst_and     = (op17 == OP17_AND);
    assign inst_or      = (op17 == OP17_OR);
    assign inst_xor     = (op17 == OP17_XOR);
    assign inst_sll_w   = (op17 == OP17_SLL_W);
    assign inst_srl_w   = (op17 == OP17_SRL_W);
    assign inst_sra_w   = (op17 == OP17_SRA_W);
    assign inst_slli_w  = (op17 == OP17_SLLI_W);
    assign inst_srli_w  = (op17 == OP17_SRLI_W);
    assign inst_srai_w  = (op17 == OP17_SRAI_W);
    assign inst_slti    = (op10 == OP10_SLTI);
    assign inst_sltui   = (op10 == OP10_SLTUI);
    assign inst_addi_w  = (op10 == OP10_ADDI_W);
    assign inst_andi    = (op10 == OP10_ANDI);
    assign inst_ori     = (op10 == OP10_ORI);
    assign inst_xori    = (op10 == OP10_XORI);
    assign inst_ld_w    = (op10 == OP10_LD_W);
    assign inst_st_w    = (op10 == OP10_ST_W);
    assign inst_lu12i_w = (op7 == OP7_LU12I_W);
    assign inst_jirl    = (op6 == OP6_JIRL);
    assign inst_b       = (op6 == OP6_B);
    assign inst_bl      = (op6 == OP6_BL);

    always_comb begin
        case (op6)
            OP6_BEQ:  br_kind = BR_BEQ;
            OP6_BNE:  br_kind = BR_BNE;
            OP6_BLT:  br_kind = BR_BLT;
            OP6_BGE:  br_kind = BR_BGE;
            OP6_BLTU: br_kind = BR_BLTU;
            OP6_BGEU: br_kind = BR_BGEU;
            OP6_B:    br_kind = BR_B;
            OP6_BL:   br_kind = BR_BL;
            OP6_JIRL: br_kind = BR_JIRL;
            default:  br_kind = BR_NONE;
        endcase
    end

    assign is_cond_br = (br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU});

    always_comb begin
        alu_op           = '0;
        // address and link adds go through the same adder
        alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w | inst_jirl | inst_bl;
        alu_op[ALU_SUB]  = inst_sub_w;
        alu_op[ALU_SLT]  = inst_slt | inst_slti;
        alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        alu_op[ALU_AND]  = inst_and | inst_andi;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or | inst_ori;
        alu_op[ALU_XOR]  = inst_xor | inst_xori;
        alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        alu_op[ALU_LUI]  = inst_lu12i_w;
    end

    assign need_ui12 = inst_andi | inst_ori | inst_xori;
    assign src2_is_4 = inst_jirl | inst_bl; // link value pc+4

    assign imm = src2_is_4    ? 32'd4 :
                 need_ui12    ? {20'b0, i12} :
                 inst_lu12i_w ? {i20, 12'b0} :
                                {{20{i12[11]}}, i12}; // ui5 shifts land here too

    assign br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0} :
                                          {{14{i16[15]}}, i16, 2'b0};

    always_comb begin
        ctrl.alu_op      = alu_op;
        ctrl.br_kind     = br_kind;
        ctrl.src1_is_pc  = inst_jirl | inst_bl;
        ctrl.src2_is_imm = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                         | inst_slti | inst_sltui | need_ui12 | inst_lu12i_w
                         | inst_ld_w | inst_st_w | src2_is_4;
        ctrl.gr_we       = ~(inst_st_w | is_cond_br | inst_b);
        ctrl.mem_we      = inst_st_w;
        ctrl.load        = inst_ld_w;
        ctrl.dest        = inst_bl ? 5'd1 : rd;
        ctrl.raddr1      = rj;
        ctrl.raddr2      = (is_cond_br | inst_st_w) ? rd : rk; // compare / store data in rd
        ctrl.imm         = imm;
        ctrl.br_offs     = br_offs;
    end

endmodule

`default_nettype wire

//--- src/operand_read.sv
`default_nettype none

module operand_read (
    input  logic          clk,
    input  logic          reset,
    input  id_pkg::ctrl_t ctrl,
    input  id_pkg::fwd_t  es_fwd,
    input  id_pkg::fwd_t  ms_fwd,
    input  id_pkg::fwd_t  ws_fwd,
    output id_pkg::xlen_t rj_value,
    output id_pkg::xlen_t rkd_value,
    output logic          load_hazard
);
    import id_pkg::*;

    xlen_t rf [32];
    xlen_t rf_rdata1;
    xlen_t rf_rdata2;

    // nearest stage wins, r0 never forwards
    function automatic xlen_t fwd_pick(input reg_addr_t addr, input xlen_t file_val,
                                       input fwd_t es, input fwd_t ms, input fwd_t ws);
        xlen_t val;
        val = file_val;
        if (addr != '0) begin
            if (es.we && es.dest == addr) begin
                val = es.result;
            end else if (ms.we && ms.dest == addr) begin
                val = ms.result;
            end else if (ws.we && ws.dest == addr) begin
                val = ws.result;
            end
        end
        return val;
    endfunction

    function automatic logic load_hit(input reg_addr_t addr, input fwd_t f);
        return f.load && (f.dest == addr) && (addr != '0);
    endfunction

    always_ff @(posedge clk) begin
        if (ws_fwd.we && ws_fwd.dest != '0) begin
            rf[ws_fwd.dest] <= ws_fwd.result;
        end
    end

    assign rf_rdata1 = (ctrl.raddr1 == '0) ? '0 : rf[ctrl.raddr1];
    assign rf_rdata2 = (ctrl.raddr2 == '0) ? '0 : rf[ctrl.raddr2];

    assign rj_value  = fwd_pick(ctrl.raddr1, rf_rdata1, es_fwd, ms_fwd, ws_fwd);
    assign rkd_value = fwd_pick(ctrl.raddr2, rf_rdata2, es_fwd, ms_fwd, ws_fwd);

    // load data not back yet in es or ms
    assign load_hazard = load_hit(ctrl.raddr1, es_fwd) || load_hit(ctrl.raddr2, es_fwd)
                      || load_hit(ctrl.raddr1, ms_fwd) || load_hit(ctrl.raddr2, ms_fwd);

    a_r0_src1: assert property (@(posedge clk) disable iff (reset)
        (ctrl.raddr1 == '0) |-> (rj_value == '0))
        else $error("r0 read on src1 returned nonzero");

    a_r0_src2: assert property (@(posedge clk) disable iff (reset)
        (ctrl.raddr2 == '0) |-> (rkd_value == '0))
        else $error("r0 read on src2 returned nonzero");

endmodule

`default_nettype wire

//--- src/branch_resolve.sv
`default_nettype none

module branch_resolve (
    input  logic            valid,
    input  id_pkg::xlen_t   pc,
    input  id_pkg::ctrl_t   ctrl,
    input  id_pkg::xlen_t   rj_value,
    input  id_pkg::xlen_t   rkd_value,
    input  logic            load_hazard,
    output id_pkg::branch_t br_bus
);
    import id_pkg::*;

    logic  rj_eq_rd;
    logic  rj_lt_rd;
    logic  rj_ltu_rd;
    logic  cond;
    xlen_t base;

    assign rj_eq_rd  = (rj_value == rkd_value);
    assign rj_lt_rd  = ($signed(rj_value) < $signed(rkd_value));
    assign rj_ltu_rd = (rj_value < rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:               cond = rj_eq_rd;
            BR_BNE:               cond = !rj_eq_rd;
            BR_BLT:               cond = rj_lt_rd;
            BR_BGE:               cond = !rj_lt_rd;
            BR_BLTU:              cond = rj_ltu_rd;
            BR_BGEU:              cond = !rj_ltu_rd;
            BR_B, BR_BL, BR_JIRL: cond = 1'b1;
            default:              cond = 1'b0;
        endcase
    end

    assign base = (ctrl.br_kind == BR_JIRL) ? rj_value : pc; // register-relative jump

    always_comb begin
        br_bus.stall  = valid && load_hazard; // operands not ready, fetch waits
        br_bus.taken  = cond && valid && !br_bus.stall;
        br_bus.target = base + ctrl.br_offs;
    end

    // a redirect with stale operands would send fetch to a wrong target
    always_comb begin
        a_no_taken_on_stall: assert final (!(br_bus.taken && br_bus.stall))
            else $error("branch taken while operands stalled");
    end

endmodule

`default_nettype wire

//--- src/id_stage.sv
`default_nettype none

module id_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_valid,
    input  id_pkg::fetch_pkt_t fs_bus,
    output logic               ds_allowin,
    input  logic               es_allowin,
    output logic               ds_to_es_valid,
    output id_pkg::issue_pkt_t ds_to_es_bus,
    output id_pkg::branch_t    br_bus,
    input  id_pkg::fwd_t       es_fwd,
    input  id_pkg::fwd_t       ms_fwd,
    input  id_pkg::fwd_t       ws_fwd
);
    import id_pkg::*;

    logic       ds_valid;
    logic       ds_ready_go;
    fetch_pkt_t fs_bus_r;
    ctrl_t      ctrl;
    xlen_t      rj_value;
    xlen_t      rkd_value;
    logic       load_hazard;

    assign ds_ready_go    = !load_hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            // taken branch leaving, drop the slot behind it
            ds_valid <= fs_valid && !br_bus.taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            fs_bus_r <= fs_bus;
        end
    end

    inst_decoder u_decoder (
        .inst (fs_bus_r.inst),
        .ctrl (ctrl)
    );

    operand_read u_operands (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .es_fwd      (es_fwd),
        .ms_fwd      (ms_fwd),
        .ws_fwd      (ws_fwd),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .load_hazard (load_hazard)
    );

    branch_resolve u_branch (
        .valid       (ds_valid),
        .pc          (fs_bus_r.pc),
        .ctrl        (ctrl),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .load_hazard (load_hazard),
        .br_bus      (br_bus)
    );

    always_comb begin
        ds_to_es_bus.alu_op      = ctrl.alu_op;
        ds_to_es_bus.load        = ctrl.load;
        ds_to_es_bus.src1_is_pc  = ctrl.src1_is_pc;
        ds_to_es_bus.src2_is_imm = ctrl.src2_is_imm;
        ds_to_es_bus.gr_we       = ctrl.gr_we;
        ds_to_es_bus.mem_we      = ctrl.mem_we;
        ds_to_es_bus.dest        = ctrl.dest;
        ds_to_es_bus.imm         = ctrl.imm;
        ds_to_es_bus.rj_value    = rj_value;
        ds_to_es_bus.rkd_value   = rkd_value;
        ds_to_es_bus.pc          = fs_bus_r.pc;
    end

    a_no_issue_on_hazard: assert property (@(posedge clk) disable iff (reset)
        load_hazard |-> !ds_to_es_valid)
        else $error("issued with a pending load-use hazard");

endmodule

`default_nettype wire

//--- tb/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// instruction kinds, 0..10 are the register ALU ops in alu_op bit order
localparam int K_SRAI  = 13;
localparam int K_ADDI  = 14;
localparam int K_ANDI  = 17;
localparam int K_ORI   = 18;
localparam int K_XORI  = 19;
localparam int K_LU12I = 20;
localparam int K_LD    = 21;
localparam int K_ST    = 22;
localparam int K_BEQ   = 23;
localparam int K_BNE   = 24;
localparam int K_BLT   = 25;
localparam int K_BGE   = 26;
localparam int K_BLTU  = 27;
localparam int K_BGEU  = 28;
localparam int K_B     = 29;
localparam int K_BL    = 30;
localparam int K_JIRL  = 31;

typedef struct packed {
    issue_pkt_t issue;
    branch_t    br;
    logic       hazard;
} expect_t;

xlen_t rng_state = 32'd91;

function automatic xlen_t xorshift32(input xlen_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic xlen_t rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// {field width, field value}
function automatic logic [21:0] opcode_of(input int k);
    case (k)
        0:       return {5'd17, OP17_ADD_W};
        1:       return {5'd17, OP17_SUB_W};
        2:       return {5'd17, OP17_SLT};
        3:       return {5'd17, OP17_SLTU};
        4:       return {5'd17, OP17_AND};
        5:       return {5'd17, OP17_NOR};
        6:       return {5'd17, OP17_OR};
        7:       return {5'd17, OP17_XOR};
        8:       return {5'd17, OP17_SLL_W};
        9:       return {5'd17, OP17_SRL_W};
        10:      return {5'd17, OP17_SRA_W};
        11:      return {5'd17, OP17_SLLI_W};
        12:      return {5'd17, OP17_SRLI_W};
        13:      return {5'd17, OP17_SRAI_W};
        14:      return {5'd10, 7'b0, OP10_ADDI_W};
        15:      return {5'd10, 7'b0, OP10_SLTI};
        16:      return {5'd10, 7'b0, OP10_SLTUI};
        17:      return {5'd10, 7'b0, OP10_ANDI};
        18:      return {5'd10, 7'b0, OP10_ORI};
        19:      return {5'd10, 7'b0, OP10_XORI};
        20:      return {5'd7, 10'b0, OP7_LU12I_W};
        21:      return {5'd10, 7'b0, OP10_LD_W};
        22:      return {5'd10, 7'b0, OP10_ST_W};
        23:      return {5'd6, 11'b0, OP6_BEQ};
        24:      return {5'd6, 11'b0, OP6_BNE};
        25:      return {5'd6, 11'b0, OP6_BLT};
        26:      return {5'd6, 11'b0, OP6_BGE};
        27:      return {5'd6, 11'b0, OP6_BLTU};
        28:      return {5'd6, 11'b0, OP6_BGEU};
        29:      return {5'd6, 11'b0, OP6_B};
        30:      return {5'd6, 11'b0, OP6_BL};
        default: return {5'd6, 11'b0, OP6_JIRL};
    endcase
endfunction

// r supplies the immediate or offset bits
function automatic xlen_t encode(input int k, input reg_addr_t rd, input reg_addr_t rj,
                                 input reg_addr_t rk, input xlen_t r);
    logic [21:0] op;
    xlen_t       inst;
    op = opcode_of(k);
    inst = xlen_t'(op[16:0]) << (32 - op[21:17]);
    if (k <= K_SRAI)
        inst |= {17'b0, rk, rj, rd}; // ui5 rides in the rk slot
    else if (k == K_LU12I)
        inst |= {7'b0, r[19:0], rd};
    else if (k <= K_ST)
        inst |= {10'b0, r[11:0], rj, rd};
    else if (k == K_B || k == K_BL)
        inst |= {6'b0, r[15:0], r[25:16]};
    else
        inst |= {6'b0, r[15:0], rj, rd};
    return inst;
endfunction

function automatic int kind_of(input xlen_t inst);
    logic [21:0] op;
    for (int k = 0; k < 32; k++) begin
        op = opcode_of(k);
        if ((inst >> (32 - op[21:17])) == xlen_t'(op[16:0]))
            return k;
    end
    return -1;
endfunction

function automatic xlen_t read_src(input reg_addr_t a, input xlen_t rf [32],
                                   input fwd_t es, input fwd_t ms, input fwd_t ws);
    if (a == '0)
        return '0;
    if (es.we && es.dest == a)
        return es.result;
    if (ms.we && ms.dest == a)
        return ms.result;
    if (ws.we && ws.dest == a)
        return ws.result;
    return rf[a];
endfunction

function automatic logic load_wait(input reg_addr_t a, input fwd_t es, input fwd_t ms);
    return (a != '0) && ((es.load && es.dest == a) || (ms.load && ms.dest == a));
endfunction

function automatic expect_t ref_stage(input xlen_t inst, input xlen_t pc, input xlen_t rf [32],
                                      input fwd_t es, input fwd_t ms, input fwd_t ws);
    expect_t   e;
    int        k;
    logic      cond_br;
    logic      cond;
    reg_addr_t rd;
    reg_addr_t rj;
    reg_addr_t a2;
    xlen_t     offs;
    e = '0;
    k = kind_of(inst);
    rd = inst[4:0];
    rj = inst[9:5];
    cond_br = (k >= K_BEQ && k <= K_BGEU);
    a2 = (cond_br || k == K_ST) ? rd : inst[14:10];

    if (k >= 0 && k <= 10)
        e.issue.alu_op[k] = 1'b1;
    else if (k >= 11 && k <= K_SRAI)
        e.issue.alu_op[k - 3] = 1'b1; // shift-immediate maps onto sll/srl/sra
    else if (k == K_ADDI || k == K_LD || k == K_ST || k == K_BL || k == K_JIRL)
        e.issue.alu_op[ALU_ADD] = 1'b1;
    else if (k == 15)
        e.issue.alu_op[ALU_SLT] = 1'b1;
    else if (k == 16)
        e.issue.alu_op[ALU_SLTU] = 1'b1;
    else if (k == K_ANDI)
        e.issue.alu_op[ALU_AND] = 1'b1;
    else if (k == K_ORI)
        e.issue.alu_op[ALU_OR] = 1'b1;
    else if (k == K_XORI)
        e.issue.alu_op[ALU_XOR] = 1'b1;
    else if (k == K_LU12I)
        e.issue.alu_op[ALU_LUI] = 1'b1;

    e.issue.load        = (k == K_LD);
    e.issue.mem_we      = (k == K_ST);
    e.issue.src1_is_pc  = (k == K_BL || k == K_JIRL);
    e.issue.src2_is_imm = (k > 10 && k <= K_ST) || k == K_BL || k == K_JIRL;
    e.issue.gr_we       = !(k == K_ST || cond_br || k == K_B);
    e.issue.dest        = (k == K_BL) ? 5'd1 : rd;
    case (k)
        K_BL, K_JIRL:          e.issue.imm = 32'd4;
        K_ANDI, K_ORI, K_XORI: e.issue.imm = {20'b0, inst[21:10]};
        K_LU12I:               e.issue.imm = {inst[24:5], 12'b0};
        default:               e.issue.imm = {{20{inst[21]}}, inst[21:10]};
    endcase
    e.issue.rj_value  = read_src(rj, rf, es, ms, ws);
    e.issue.rkd_value = read_src(a2, rf, es, ms, ws);
    e.issue.pc        = pc;
    e.hazard = load_wait(rj, es, ms) || load_wait(a2, es, ms);

    if (k == K_B || k == K_BL)
        offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
    else
        offs = {{14{inst[25]}}, inst[25:10], 2'b0};
    case (k)
        K_BEQ:             cond = (e.issue.rj_value == e.issue.rkd_value);
        K_BNE:             cond = (e.issue.rj_value != e.issue.rkd_value);
        K_BLT:             cond = ($signed(e.issue.rj_value) < $signed(e.issue.rkd_value));
        K_BGE:             cond = ($signed(e.issue.rj_value) >= $signed(e.issue.rkd_value));
        K_BLTU:            cond = (e.issue.rj_value < e.issue.rkd_value);
        K_BGEU:            cond = (e.issue.rj_value >= e.issue.rkd_value);
        K_B, K_BL, K_JIRL: cond = 1'b1;
        default:           cond = 1'b0;
    endcase
    e.br.stall  = e.hazard;
    e.br.taken  = cond && !e.hazard;
    e.br.target = ((k == K_JIRL) ? e.issue.rj_value : pc) + offs;
    return e;
endfunction

`endif

//--- tb/id_stage_tb.sv
`default_nettype none

module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import id_pkg::*;

    `include "id_ref_model.svh"

    localparam int MAX_CYCLES = 2000; // tests run in well under 700 cycles

    logic       clk;
    logic       reset;
    logic       fs_valid;
    fetch_pkt_t fs_bus;
    logic       ds_allowin;
    logic       es_allowin;
    logic       ds_to_es_valid;
    issue_pkt_t ds_to_es_bus;
    branch_t    br_bus;
    fwd_t       es_fwd;
    fwd_t       ms_fwd;
    fwd_t       ws_fwd;

    xlen_t      shadow [32];
    logic       m_valid; // model of the stage valid bit
    fetch_pkt_t m_pkt;
    xlen_t      issued_q [$];
    xlen_t      sent_q [$];
    xlen_t      next_pc;
    logic       bp_done;
    int         cycles;
    int         checks;
    int         errors;
    int         test_errors;
    int         tests_run;
    int         tests_failed;

    id_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run hung, cycle limit of %0d reached", MAX_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [159:0] exp, input logic [159:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // outputs are settled mid-cycle, inputs only move 10 ns after the edge
    always @(negedge clk) begin : compare
        expect_t e;
        logic    accept;
        e = '0;
        if (reset)
            m_valid = 1'b0;
        if (m_valid) begin
            e = ref_stage(m_pkt.inst, m_pkt.pc, shadow, es_fwd, ms_fwd, ws_fwd);
            check("ds_to_es_valid", !e.hazard, ds_to_es_valid);
            check("br_bus.stall", e.br.stall, br_bus.stall);
            check("br_bus.taken", e.br.taken, br_bus.taken);
            check("ds_allowin", !e.hazard && es_allowin, ds_allowin);
            if (!e.hazard)
                check("ds_to_es_bus", e.issue, ds_to_es_bus);
            if (e.br.taken)
                check("br_bus.target", e.br.target, br_bus.target);
        end else begin
            check("ds_to_es_valid", 1'b0, ds_to_es_valid);
            check("br_bus.stall", 1'b0, br_bus.stall);
            check("br_bus.taken", 1'b0, br_bus.taken);
            check("ds_allowin", 1'b1, ds_allowin);
        end
        if (!reset) begin
            if (ds_to_es_valid && es_allowin)
                issued_q.push_back(ds_to_es_bus.pc);
            accept = !m_valid || (!e.hazard && es_allowin);
            if (accept) begin
                if (fs_valid)
                    m_pkt = fs_bus;
                m_valid = fs_valid && !e.br.taken; // slot behind a taken branch is dropped
            end
            if (ws_fwd.we && ws_fwd.dest != '0)
                shadow[ws_fwd.dest] = ws_fwd.result;
        end
    end

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    // offer one instruction until the stage takes it
    task automatic send(input xlen_t inst);
        logic acc;
        fs_valid = 1'b1;
        fs_bus.pc = next_pc;
        fs_bus.inst = inst;
        sent_q.push_back(next_pc);
        next_pc += 4;
        do begin
            @(negedge clk);
            acc = ds_allowin;
            tick();
        end while (!acc);
        fs_valid = 1'b0;
    endtask

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(rand32());
    endfunction

    function automatic int rand_alu_kind();
        return int'(rand32() % 23);
    endfunction

    // mostly aimed at the sources so priority gets exercised
    function automatic fwd_t rand_fwd(input reg_addr_t a, input reg_addr_t b);
        fwd_t  f;
        xlen_t r;
        r = rand32();
        f.we = r[0];
        f.load = 1'b0;
        f.dest = (r[2:1] == 2'd0) ? a : (r[2:1] == 2'd1) ? b : reg_addr_t'(r[7:3]);
        f.result = rand32();
        return f;
    endfunction

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errors)
            tests_failed++;
        $display("test %-14s %s, %0d errors", name,
                 (errors == test_errors) ? "ok" : "failed", errors - test_errors);
    endtask

    initial begin : main
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t x;
        xlen_t     r;
        logic      same;
        reset = 1'b1;
        fs_valid = 1'b0;
        fs_bus = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        m_valid = 1'b0;
        m_pkt = '0;
        next_pc = 32'h1c00_0000;
        bp_done = 1'b0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;

        begin_test();
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        repeat (2) tick();
        end_test("reset");

        begin_test();
        for (int i = 1; i < 32; i++) begin
            ws_fwd = '{1'b1, 1'b0, reg_addr_t'(i), rand32()};
            tick();
        end
        ws_fwd = '0;
        for (int i = 1; i < 32; i += 2) // i+1 wraps to r0 at the end
            send(encode(0, rand_reg(), reg_addr_t'(i), reg_addr_t'(i + 1), rand32()));
        for (int i = 0; i < 40; i++) begin
            rj = (i % 4 == 0) ? '0 : rand_reg();
            rk = rand_reg();
            send(encode(int'(rand32() % 11), rand_reg(), rj, rk, rand32()));
            es_fwd = rand_fwd(rj, rk); // live while this one is held
            ms_fwd = rand_fwd(rj, rk);
            ws_fwd = rand_fwd(rj, rk);
        end
        es_fwd = '0;
        ms_fwd = '0;
        ws_fwd = '0;
        repeat (2) tick();
        end_test("operands");

        begin_test();
        for (int i = 0; i < 60; i++)
            send(encode(rand_alu_kind(), rand_reg(), rand_reg(), rand_reg(), rand32()));
        repeat (2) tick();
        end_test("alu_mem_decode");

        begin_test();
        for (int i = 0; i < 40; i++) begin
            rj = rand_reg();
            rd = (rand32() % 4 == 0) ? rj : rand_reg();
            send(encode(K_BEQ + int'(rand32() % 9), rd, rj, rand_reg(), rand32()));
            send(encode(K_ADDI, rand_reg(), rand_reg(), '0, rand32())); // slot behind
        end
        repeat (2) tick();
        end_test("branches");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            x = reg_addr_t'(1 + rand32() % 31);
            r = rand32();
            if (r[0])
                es_fwd = '{1'b1, 1'b1, x, rand32()};
            else
                ms_fwd = '{1'b1, 1'b1, x, rand32()};
            if (r[1])
                send(encode(K_BEQ, rand_reg(), x, '0, r)); // load feeds rj
            else
                send(encode(0, rand_reg(), rand_reg(), x, r));
            repeat (1 + rand32() % 3) tick();
            es_fwd.load = 1'b0; // load data has arrived
            ms_fwd.load = 1'b0;
            do begin
                @(negedge clk);
            end while (!ds_to_es_valid);
            tick();
            es_fwd = '0;
            ms_fwd = '0;
        end
        tick();
        end_test("load_use");

        begin_test();
        sent_q.delete();
        issued_q.delete();
        fork
            begin
                for (int i = 0; i < 30; i++)
                    send(encode(rand_alu_kind(), rand_reg(), rand_reg(), rand_reg(), rand32()));
                bp_done = 1'b1;
            end
            begin
                while (!bp_done) begin
                    es_allowin = 1'b0;
                    repeat (1 + rand32() % 4) tick();
                    es_allowin = 1'b1;
                    repeat (rand32() % 3) tick();
                end
            end
        join
        es_allowin = 1'b1;
        repeat (2) tick();
        same = (issued_q.size() == sent_q.size());
        for (int i = 0; same && i < sent_q.size(); i++)
            same = (issued_q[i] == sent_q[i]);
        assert (same) else begin
            $display("back-pressure run issued %0d of %0d instructions, lost or duplicated",
                     issued_q.size(), sent_q.size());
            errors++;
        end
        end_test("back_pressure");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
src/id_pkg.sv
+incdir+tb
src/inst_decoder.sv
src/operand_read.sv
src/branch_resolve.sv
src/id_stage.sv
tb/id_stage_tb.sv
